// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - source/mem_pkg.sv
  - source/dcache_pkg.sv
  - source/dcache_lines.sv
  - source/mshr_table.sv
  - source/dcache_ctrl.sv
  - source/dcache.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/mem_model.sv
      - testbench/dcache_tb.sv

// File: include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address and data width
`define DC_XLEN 32

// main array geometry
`define DC_N_LINES 16
`define DC_BLOCK_BYTES 8

// miss status holding table depth
`define DC_N_MSHR 4

// memory bus tag width, tag zero means no transaction
`define DC_MEM_TAG_BITS 4

`endif

// File: source/dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     req_valid,
    input  wire mem_pkg::mem_op_t         req_op,
    input  wire dcache_pkg::access_size_t req_size,
    input  wire mem_pkg::mem_addr_t       req_addr,
    input  wire logic [`DC_XLEN-1:0]      req_wdata,
    output logic                          stall,
    output logic                          resp_valid,
    output logic [`DC_XLEN-1:0]           resp_data,
    output mem_pkg::bus_cmd_t             mem_command,
    output mem_pkg::mem_addr_t            mem_addr,
    output mem_pkg::mem_block_t           mem_wdata,
    input  wire mem_pkg::mem_tag_t        mem_accept_tag,
    input  wire mem_pkg::mem_block_t      mem_rdata,
    input  wire mem_pkg::mem_tag_t        mem_resp_tag
);
    import mem_pkg::*;
    import dcache_pkg::*;

    logic                        hit, fwd_hit, write_en, fwd_install, alloc_valid, evict_valid;
    mem_block_t                  hit_block, fwd_block, evict_block;
    mem_addr_t                   alloc_addr, evict_addr, wait_addr;
    logic [$clog2(`DC_N_MSHR):0] n_free;
    fill_t                       fill;
    mem_op_t                     wait_op;
    access_size_t                wait_size;
    logic [`DC_XLEN-1:0]         wait_wdata;

    dcache_lines u_lines (
        .clock, .reset, .req_valid,
        .req_op(wait_op), .req_size(wait_size), .req_addr(wait_addr), .req_wdata(wait_wdata),
        .write_en, .fill, .fwd_install, .fwd_block,
        .hit, .hit_block, .evict_valid, .evict_addr, .evict_block
    );

    // only a forwarded request releases its write entry
    mshr_table u_mshr (
        .clock, .reset, .alloc_valid, .alloc_addr, .evict_valid, .evict_addr, .evict_block,
        .req_valid(fwd_install), .req_addr,
        .mem_accept_tag, .mem_rdata, .mem_resp_tag,
        .n_free, .fill, .fwd_hit, .fwd_block, .mem_command, .mem_addr, .mem_wdata
    );

    dcache_ctrl u_ctrl (
        .clock, .reset, .req_valid, .req_op, .req_size, .req_addr, .req_wdata,
        .hit, .hit_block, .fwd_hit, .fwd_block, .n_free, .fill,
        .stall, .resp_valid, .resp_data, .write_en, .fwd_install, .alloc_valid, .alloc_addr,
        .wait_op, .wait_size, .wait_addr, .wait_wdata
    );

endmodule

`default_nettype wire

// File: source/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     req_valid,
    input  wire mem_pkg::mem_op_t         req_op,
    input  wire dcache_pkg::access_size_t req_size,
    input  wire mem_pkg::mem_addr_t       req_addr,
    input  wire logic [`DC_XLEN-1:0]      req_wdata,
    input  wire logic                     hit,
    input  wire mem_pkg::mem_block_t      hit_block,
    input  wire logic                     fwd_hit,
    input  wire mem_pkg::mem_block_t      fwd_block,
    input  wire logic [$clog2(`DC_N_MSHR):0] n_free,
    input  wire dcache_pkg::fill_t        fill,
    output logic                          stall,
    output logic                          resp_valid,
    output logic [`DC_XLEN-1:0]           resp_data,
    output logic                          write_en,
    output logic                          fwd_install,
    output logic                          alloc_valid,
    output mem_pkg::mem_addr_t            alloc_addr,
    output mem_pkg::mem_op_t              wait_op,
    output dcache_pkg::access_size_t      wait_size,
    output mem_pkg::mem_addr_t            wait_addr,
    output logic [`DC_XLEN-1:0]           wait_wdata
);
    import mem_pkg::*;
    import dcache_pkg::*;

    dc_state_t           state, next_state;
    mem_op_t             held_op;
    access_size_t        held_size;
    mem_addr_t           held_addr;
    logic [`DC_XLEN-1:0] held_wdata;

    logic                take, miss, fill_match;
    mem_block_t          resp_block;

    assign stall = (state != st_ready);

    // live request while ready, the stored miss otherwise
    assign wait_op    = (state == st_ready) ? req_op    : held_op;
    assign wait_size  = (state == st_ready) ? req_size  : held_size;
    assign wait_addr  = (state == st_ready) ? req_addr  : held_addr;
    assign wait_wdata = (state == st_ready) ? req_wdata : held_wdata;

    assign take        = (state == st_ready) && req_valid;
    assign write_en    = take && hit && (req_op == mem_write);
    assign fwd_install = take && !hit && fwd_hit;
    assign miss        = take && !hit && !fwd_hit;
    assign fill_match  = (state == st_wait) && fill.valid &&
                         (fill.line_addr[`DC_XLEN-1:offset_bits] == wait_addr[`DC_XLEN-1:offset_bits]);

    always_comb begin
        next_state = state;
        case (state)
            st_ready:     if (miss) next_state = (n_free < 2) ? st_wait_mshr : st_wait;
            st_wait_mshr: if (n_free >= 2) next_state = st_wait;  // room for read and write-back
            st_wait:      if (fill_match) next_state = st_ready;
            default:      next_state = st_ready;
        endcase
    end

    assign alloc_valid = (next_state == st_wait) && (state != st_wait);
    assign alloc_addr  = {wait_addr[`DC_XLEN-1:offset_bits], {offset_bits{1'b0}}};
    assign resp_block  = fill_match ? fill.block : (hit ? hit_block : fwd_block);

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_ready;
            resp_valid <= 1'b0;
        end else begin
            state      <= next_state;
            resp_valid <= (take && (hit || fwd_hit)) || fill_match;
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_ready) begin  // keep a copy, the pipeline may move on
            held_op    <= req_op;
            held_size  <= req_size;
            held_addr  <= req_addr;
            held_wdata <= req_wdata;
        end
        resp_data <= (wait_op == mem_write) ? '0 :
                     load_field(resp_block, wait_addr[offset_bits-1:0], wait_size);
    end

endmodule

`default_nettype wire

// File: source/dcache_lines.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_lines (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  req_valid,
    input  wire mem_pkg::mem_op_t      req_op,
    input  wire dcache_pkg::access_size_t req_size,
    input  wire mem_pkg::mem_addr_t    req_addr,
    input  wire logic [`DC_XLEN-1:0]   req_wdata,
    input  wire logic                  write_en,     // store hit
    input  wire dcache_pkg::fill_t     fill,
    input  wire logic                  fwd_install,
    input  wire mem_pkg::mem_block_t   fwd_block,
    output logic                       hit,
    output mem_pkg::mem_block_t        hit_block,
    output logic                       evict_valid,
    output mem_pkg::mem_addr_t         evict_addr,
    output mem_pkg::mem_block_t        evict_block
);
    import mem_pkg::*;
    import dcache_pkg::*;

    cache_line_t   lines_q [`DC_N_LINES];

    line_index_t   req_idx;
    line_tag_t     req_tag;
    block_offset_t req_offset;

    logic          inst_valid;
    line_index_t   inst_idx;
    cache_line_t   inst_line;
    cache_line_t   victim;

    assign req_offset = req_addr[offset_bits-1:0];
    assign req_idx    = req_addr[offset_bits +: index_bits];
    assign req_tag    = req_addr[`DC_XLEN-1 -: tag_bits];

    // lookup
    assign hit       = req_valid && lines_q[req_idx].valid && (lines_q[req_idx].tag == req_tag);
    assign hit_block = lines_q[req_idx].block;

    always_comb begin : install_select
        inst_valid = fill.valid || fwd_install;
        inst_line.valid = 1'b1;
        if (fill.valid) begin
            inst_idx        = fill.line_addr[offset_bits +: index_bits];
            inst_line.tag   = fill.line_addr[`DC_XLEN-1 -: tag_bits];
            inst_line.block = fill.block;
            inst_line.dirty = 1'b0;
        end else begin
            inst_idx        = req_idx;
            inst_line.tag   = req_tag;
            inst_line.block = fwd_block;
            inst_line.dirty = 1'b1;  // the write entry is dropped, so the line owns the data
        end

        // the request behind the install is a store
        if (req_op == mem_write) begin
            inst_line.block = merge_store(inst_line.block, req_offset, req_size, req_wdata);
            inst_line.dirty = 1'b1;
        end

        victim      = lines_q[inst_idx];
        evict_valid = inst_valid && victim.valid && victim.dirty && (victim.tag != inst_line.tag);
        evict_addr  = {victim.tag, inst_idx, {offset_bits{1'b0}}};
        evict_block = victim.block;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_N_LINES; i++) begin
                lines_q[i].valid <= 1'b0;
                lines_q[i].dirty <= 1'b0;
            end
        end else if (inst_valid) begin
            lines_q[inst_idx] <= inst_line;
        end else if (write_en) begin
            lines_q[req_idx].block <= merge_store(lines_q[req_idx].block, req_offset,
                                                  req_size, req_wdata);
            lines_q[req_idx].dirty <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    localparam int offset_bits = $clog2(`DC_BLOCK_BYTES);
    localparam int index_bits  = $clog2(`DC_N_LINES);
    localparam int tag_bits    = `DC_XLEN - index_bits - offset_bits;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    typedef enum logic [1:0] {
        st_ready     = 2'd0,
        st_wait_mshr = 2'd1,  // miss seen, not enough free entries
        st_wait      = 2'd2   // read entry allocated, waiting for the fill
    } dc_state_t;

    typedef logic [offset_bits-1:0] block_offset_t;
    typedef logic [index_bits-1:0]  line_index_t;
    typedef logic [tag_bits-1:0]    line_tag_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        line_tag_t           tag;
        mem_pkg::mem_block_t block;
    } cache_line_t;

    typedef struct packed {
        logic                valid;
        mem_pkg::mem_op_t    op;
        mem_pkg::mem_addr_t  line_addr;
        mem_pkg::mem_tag_t   tag;        // zero until the bus accepts a load
        mem_pkg::mem_block_t block;
    } mshr_entry_t;

    typedef struct packed {
        logic                valid;
        mem_pkg::mem_addr_t  line_addr;
        mem_pkg::mem_block_t block;
    } fill_t;

    // write a byte, half or word into a block
    function automatic mem_pkg::mem_block_t merge_store(
        input mem_pkg::mem_block_t     block,
        input block_offset_t           offset,
        input access_size_t            size,
        input logic [`DC_XLEN-1:0]     wdata
    );
        mem_pkg::mem_block_t merged;
        merged = block;
        case (size)
            size_byte: merged[8*offset +: 8] = wdata[7:0];
            size_half: merged[8*{offset[offset_bits-1:1], 1'b0} +: 16] = wdata[15:0];
            default:   merged[8*{offset[offset_bits-1:2], 2'b00} +: 32] = wdata[31:0];
        endcase
        return merged;
    endfunction

    // sized field of a block, zero extended
    function automatic logic [`DC_XLEN-1:0] load_field(
        input mem_pkg::mem_block_t block,
        input block_offset_t       offset,
        input access_size_t        size
    );
        logic [`DC_XLEN-1:0] field;
        field = '0;
        case (size)
            size_byte: field[7:0]  = block[8*offset +: 8];
            size_half: field[15:0] = block[8*{offset[offset_bits-1:1], 1'b0} +: 16];
            default:   field[31:0] = block[8*{offset[offset_bits-1:2], 2'b00} +: 32];
        endcase
        return field;
    endfunction

endpackage

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_t;

    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_t;

    typedef logic [`DC_XLEN-1:0]           mem_addr_t;
    typedef logic [`DC_MEM_TAG_BITS-1:0]   mem_tag_t;
    typedef logic [8*`DC_BLOCK_BYTES-1:0]  mem_block_t;  // one full line

endpackage

`default_nettype wire

// File: source/mshr_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module mshr_table (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  alloc_valid,
    input  wire mem_pkg::mem_addr_t    alloc_addr,
    input  wire logic                  evict_valid,
    input  wire mem_pkg::mem_addr_t    evict_addr,
    input  wire mem_pkg::mem_block_t   evict_block,
    input  wire logic                  req_valid,    // request taken by forwarding
    input  wire mem_pkg::mem_addr_t    req_addr,
    input  wire mem_pkg::mem_tag_t     mem_accept_tag,
    input  wire mem_pkg::mem_block_t   mem_rdata,
    input  wire mem_pkg::mem_tag_t     mem_resp_tag,
    output logic [$clog2(`DC_N_MSHR):0] n_free,
    output dcache_pkg::fill_t          fill,
    output logic                       fwd_hit,
    output mem_pkg::mem_block_t        fwd_block,
    output mem_pkg::bus_cmd_t          mem_command,
    output mem_pkg::mem_addr_t         mem_addr,
    output mem_pkg::mem_block_t        mem_wdata
);
    import mem_pkg::*;
    import dcache_pkg::*;

    localparam int idx_bits = $clog2(`DC_N_MSHR);

    mshr_entry_t          entries_q [`DC_N_MSHR];
    mshr_entry_t          entries_d [`DC_N_MSHR];

    logic                 issue_any;
    logic [idx_bits-1:0]  issue_idx;
    logic [idx_bits-1:0]  fwd_idx;
    logic [idx_bits-1:0]  resp_idx;
    logic                 evict_left;
    logic                 alloc_left;

    // descending scans so the lowest index wins
    always_comb begin : issue_select
        issue_any = 1'b0;
        issue_idx = '0;
        for (int i = `DC_N_MSHR-1; i >= 0; i--) begin
            if (entries_q[i].valid && entries_q[i].tag == '0 && entries_q[i].op == mem_read) begin
                issue_any = 1'b1;
                issue_idx = idx_bits'(i);
            end
        end
        // write-backs go ahead of reads
        for (int i = `DC_N_MSHR-1; i >= 0; i--) begin
            if (entries_q[i].valid && entries_q[i].tag == '0 && entries_q[i].op == mem_write) begin
                issue_any = 1'b1;
                issue_idx = idx_bits'(i);
            end
        end
    end

    always_comb begin
        mem_command = bus_none;
        if (issue_any) begin
            mem_command = (entries_q[issue_idx].op == mem_write) ? bus_store : bus_load;
        end
    end
    assign mem_addr  = entries_q[issue_idx].line_addr;
    assign mem_wdata = entries_q[issue_idx].block;

    always_comb begin : lookup
        fwd_hit  = 1'b0;
        fwd_idx  = '0;
        resp_idx = '0;
        fill     = '0;
        for (int i = 0; i < `DC_N_MSHR; i++) begin
            if (entries_q[i].valid && entries_q[i].op == mem_write &&
                entries_q[i].line_addr[`DC_XLEN-1:offset_bits] ==
                req_addr[`DC_XLEN-1:offset_bits]) begin
                fwd_hit = 1'b1;
                fwd_idx = idx_bits'(i);
            end
            if (entries_q[i].valid && entries_q[i].op == mem_read &&
                mem_resp_tag != '0 && entries_q[i].tag == mem_resp_tag) begin
                fill.valid     = 1'b1;
                fill.line_addr = entries_q[i].line_addr;
                fill.block     = mem_rdata;
                resp_idx       = idx_bits'(i);
            end
        end
    end
    assign fwd_block = entries_q[fwd_idx].block;

    always_comb begin : next_entries
        entries_d  = entries_q;
        evict_left = evict_valid;
        alloc_left = alloc_valid;

        if (issue_any && mem_accept_tag != '0) begin
            if (entries_q[issue_idx].op == mem_write)
                entries_d[issue_idx].valid = 1'b0;  // store done once accepted
            else
                entries_d[issue_idx].tag = mem_accept_tag;
        end
        if (fill.valid)
            entries_d[resp_idx].valid = 1'b0;
        if (req_valid && fwd_hit)
            entries_d[fwd_idx].valid = 1'b0;

        for (int i = 0; i < `DC_N_MSHR; i++) begin
            if (!entries_d[i].valid && evict_left) begin
                entries_d[i] = '{valid: 1'b1, op: mem_write, line_addr: evict_addr,
                                 tag: '0, block: evict_block};
                evict_left = 1'b0;
            end else if (!entries_d[i].valid && alloc_left) begin
                entries_d[i] = '{valid: 1'b1, op: mem_read, line_addr: alloc_addr,
                                 tag: '0, block: '0};
                alloc_left = 1'b0;
            end
        end
    end

    always_comb begin
        n_free = '0;
        for (int i = 0; i < `DC_N_MSHR; i++) begin
            if (!entries_q[i].valid) n_free = n_free + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_N_MSHR; i++) entries_q[i].valid <= 1'b0;
        end else begin
            entries_q <= entries_d;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
source/mem_pkg.sv
source/dcache_pkg.sv
source/dcache_lines.sv
source/mshr_table.sv
source/dcache_ctrl.sv
source/dcache.sv
testbench/tb_clock.sv
testbench/mem_model.sv
testbench/dcache_tb.sv

// File: testbench/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_tb;
    import mem_pkg::*;
    import dcache_pkg::*;

    localparam int n_requests    = 20;
    localparam int max_mem_delay = 16;  // accept wait plus response wait
    localparam int cycle_limit   = 20 * n_requests * max_mem_delay;

    logic                clock;
    logic                reset;
    logic                req_valid;
    mem_op_t             req_op;
    access_size_t        req_size;
    mem_addr_t           req_addr;
    logic [`DC_XLEN-1:0] req_wdata;
    logic                stall;
    logic                resp_valid;
    logic [`DC_XLEN-1:0] resp_data;
    bus_cmd_t            mem_command;
    mem_addr_t           mem_addr;
    mem_block_t          mem_wdata;
    mem_block_t          mem_rdata;
    mem_tag_t            mem_accept_tag;
    mem_tag_t            mem_resp_tag;
    logic                hold_stores;
    logic                fast_expected;  // hit or forward for the current request
    mem_addr_t           cur_addr;

    mem_block_t          ref_img [mem_addr_t];
    logic                res_valid [`DC_N_LINES];  // which line each slot should hold
    mem_addr_t           res_line [`DC_N_LINES];
    int                  errors;
    int                  checks;
    int                  loads_accepted = 0;
    int                  stores_accepted = 0;
    int                  cycles = 0;

    tb_clock clock_gen (.clock);

    mem_model memory (
        .clock, .reset, .hold_stores, .mem_command, .mem_addr, .mem_wdata,
        .accept_tag(mem_accept_tag), .rdata(mem_rdata), .resp_tag(mem_resp_tag)
    );

    dcache dut (
        .clock, .reset, .req_valid, .req_op, .req_size, .req_addr, .req_wdata,
        .stall, .resp_valid, .resp_data, .mem_command, .mem_addr, .mem_wdata,
        .mem_accept_tag, .mem_rdata, .mem_resp_tag
    );

    function automatic mem_addr_t line_of(input mem_addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic int slot_of(input mem_addr_t a);
        return int'(a[6:3]);  // 16 lines of 8 bytes
    endfunction

    function automatic mem_block_t ref_block(input mem_addr_t a);
        mem_addr_t line;
        line = line_of(a);
        if (ref_img.exists(line)) return ref_img[line];
        return {line ^ 32'ha5c3_0f96, line * 32'h9e37_79b1};
    endfunction

    // a plain shift finds the field of an aligned access
    function automatic logic [31:0] field_of(input mem_block_t b, input mem_addr_t a,
                                             input access_size_t size);
        mem_block_t sh;
        sh = b >> (8 * int'(a[2:0]));
        if (size == size_byte) return {24'h0, sh[7:0]};
        if (size == size_half) return {16'h0, sh[15:0]};
        return sh[31:0];
    endfunction

    function automatic mem_block_t apply_store(input mem_block_t b, input mem_addr_t a,
                                               input access_size_t size, input logic [31:0] d);
        mem_block_t mask;
        int         sh;
        mask = (size == size_byte) ? 64'hff : (size == size_half) ? 64'hffff : 64'hffff_ffff;
        sh   = 8 * int'(a[2:0]);
        return (b & ~(mask << sh)) | (({32'h0, d} & mask) << sh);
    endfunction

    a_reset_idle: assert property (@(posedge clock)
        reset |=> !stall && !resp_valid && mem_command == bus_none)
        else begin
            $display("stall, resp_valid or the bus command is active after reset");
            errors++;
        end

    a_fast_resp: assert property (@(posedge clock) disable iff (reset)
        req_valid && !stall && fast_expected |=> resp_valid && !stall)
        else begin
            $display("no response one cycle after a hit or forward at %h", cur_addr);
            errors++;
        end

    a_fast_no_load: assert property (@(posedge clock) disable iff (reset)
        req_valid && !stall && fast_expected |=> mem_command != bus_load)
        else begin
            $display("a bus load was issued for the hit or forward at %h", cur_addr);
            errors++;
        end

    a_miss_stall: assert property (@(posedge clock) disable iff (reset)
        req_valid && !stall && !fast_expected |=> stall)
        else begin
            $display("stall did not rise after the miss at %h", cur_addr);
            errors++;
        end

    a_stall_release: assert property (@(posedge clock) disable iff (reset)
        $fell(stall) |-> resp_valid)
        else begin
            $display("stall fell without a response");
            errors++;
        end

    a_load_addr: assert property (@(posedge clock) disable iff (reset)
        mem_command == bus_load |-> mem_addr == line_of(cur_addr))
        else begin
            $display("[FAIL] mem_addr: got %h, expected %h", mem_addr, line_of(cur_addr));
            errors++;
        end

    // count accepted bus transactions and check write-back data
    always @(posedge clock) begin
        if (!reset && mem_accept_tag != '0 && mem_command == bus_load)
            loads_accepted <= loads_accepted + 1;
        if (!reset && mem_accept_tag != '0 && mem_command == bus_store) begin
            stores_accepted <= stores_accepted + 1;
            checks++;
            assert (mem_wdata == ref_block(mem_addr)) else begin
                $display("[FAIL] mem_wdata for line %h: got %h, expected %h",
                         mem_addr, mem_wdata, ref_block(mem_addr));
                errors++;
            end
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout after %0d cycles, a response or the bus never came", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic access(input mem_op_t op, input access_size_t size, input mem_addr_t addr,
                          input logic [31:0] wdata, input logic forwarded);
        int          latency;
        int          loads_before;
        logic        fast;
        logic [31:0] expected;
        mem_block_t  blk;
        blk          = ref_block(addr);
        expected     = (op == mem_write) ? 32'h0 : field_of(blk, addr, size);
        fast         = forwarded || (res_valid[slot_of(addr)] &&
                                     res_line[slot_of(addr)] == line_of(addr));
        loads_before = loads_accepted;
        @(posedge clock);
        req_valid     <= 1'b1;
        req_op        <= op;
        req_size      <= size;
        req_addr      <= addr;
        req_wdata     <= wdata;
        fast_expected <= fast;
        cur_addr      <= addr;
        @(posedge clock);  // taken here since stall is low between requests
        req_valid <= 1'b0;
        req_addr  <= addr ^ 32'h0000_0040;  // the cache keeps its own copy
        req_wdata <= ~wdata;
        latency = 0;
        do begin
            @(posedge clock);
            latency++;
        end while (!resp_valid);
        checks = checks + 2;
        assert (resp_data == expected) else begin
            $display("[FAIL] resp_data at %h: got %h, expected %h", addr, resp_data, expected);
            errors++;
        end
        if (fast) begin
            assert (latency == 1) else begin
                $display("access to %h was not served in one cycle", addr);
                errors++;
            end
        end else begin
            assert (latency > 1 && loads_accepted == loads_before + 1) else begin
                $display("miss at %h did not wait for exactly one line fill", addr);
                errors++;
            end
        end
        if (op == mem_write) ref_img[line_of(addr)] = apply_store(blk, addr, size, wdata);
        res_valid[slot_of(addr)] = 1'b1;
        res_line[slot_of(addr)]  = line_of(addr);
    endtask

    task automatic drain_bus();
        do @(posedge clock); while (mem_command != bus_none);
    endtask

    task automatic expect_stores(input int expected, input string what);
        checks++;
        assert (stores_accepted == expected) else begin
            $display("%s: %0d write-backs seen, %0d expected", what, stores_accepted, expected);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors == err_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errors - err_before);
    endtask

    initial begin
        int mark;
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = mem_read;
        req_size = size_word;
        req_addr = '0;
        req_wdata = '0;
        hold_stores = 1'b0;
        fast_expected = 1'b0;
        cur_addr = '0;
        errors = 0;
        checks = 0;
        for (int i = 0; i < `DC_N_LINES; i++) res_valid[i] = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        mark = errors;
        repeat (3) @(posedge clock);
        report_test(1, "idle after reset", mark);

        mark = errors;
        access(mem_read, size_word, 32'h100, 32'h0, 1'b0);
        report_test(2, "load miss", mark);

        mark = errors;
        access(mem_read, size_half, 32'h104, 32'h0, 1'b0);
        access(mem_read, size_byte, 32'h107, 32'h0, 1'b0);
        report_test(3, "load hit", mark);

        mark = errors;
        access(mem_write, size_byte, 32'h101, 32'h0000_00a5, 1'b0);
        access(mem_write, size_half, 32'h106, 32'h0000_beef, 1'b0);
        access(mem_write, size_word, 32'h118, 32'h1234_5678, 1'b0);  // store miss
        access(mem_write, size_half, 32'h11e, 32'h0000_7777, 1'b0);
        access(mem_read, size_word, 32'h100, 32'h0, 1'b0);
        access(mem_read, size_word, 32'h104, 32'h0, 1'b0);
        access(mem_read, size_word, 32'h118, 32'h0, 1'b0);
        access(mem_read, size_word, 32'h11c, 32'h0, 1'b0);
        access(mem_read, size_byte, 32'h11f, 32'h0, 1'b0);
        report_test(4, "store merge", mark);

        mark = errors;
        access(mem_read, size_word, 32'h180, 32'h0, 1'b0);  // same slot as dirty 0x100
        drain_bus();
        expect_stores(1, "conflict miss");
        access(mem_read, size_word, 32'h100, 32'h0, 1'b0);
        access(mem_read, size_word, 32'h104, 32'h0, 1'b0);
        report_test(5, "dirty eviction", mark);

        mark = errors;
        access(mem_write, size_byte, 32'h102, 32'h0000_003c, 1'b0);
        hold_stores <= 1'b1;
        access(mem_read, size_word, 32'h180, 32'h0, 1'b0);
        access(mem_read, size_half, 32'h102, 32'h0, 1'b1);  // from the pending write entry
        hold_stores <= 1'b0;
        drain_bus();
        expect_stores(1, "forwarded write-back");
        access(mem_read, size_word, 32'h100, 32'h0, 1'b0);
        access(mem_read, size_word, 32'h200, 32'h0, 1'b0);
        drain_bus();
        expect_stores(2, "eviction after forward");
        report_test(6, "write-back forward", mark);

        repeat (4) @(posedge clock);
        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mem_model (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                hold_stores,  // leave write-backs pending
    input  wire mem_pkg::bus_cmd_t   mem_command,
    input  wire mem_pkg::mem_addr_t  mem_addr,
    input  wire mem_pkg::mem_block_t mem_wdata,
    output mem_pkg::mem_tag_t        accept_tag,
    output mem_pkg::mem_block_t      rdata,
    output mem_pkg::mem_tag_t        resp_tag
);
    import mem_pkg::*;

    mem_block_t  image [mem_addr_t];  // written lines only
    logic [31:0] lfsr;
    int          accept_wait;
    int          resp_wait;
    logic        load_pending;
    mem_tag_t    load_tag;
    mem_tag_t    next_tag;
    mem_addr_t   load_addr;

    function automatic mem_block_t fill_pattern(input mem_addr_t line);
        return {line ^ 32'ha5c3_0f96, line * 32'h9e37_79b1};
    endfunction

    // fibonacci form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int random_delay();
        int d;
        d = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_step(lfsr);  // one step per bit
            d = 2 * d + int'(lfsr[0]);
        end
        return d;
    endfunction

    initial begin
        accept_tag = '0;
        resp_tag   = '0;
        rdata      = '0;
    end

    always @(posedge clock) begin
        accept_tag <= '0;  // accept and response tags pulse for one cycle
        resp_tag   <= '0;
        if (reset) begin
            lfsr         = 32'h9b45;
            accept_wait  = 0;
            resp_wait    = 0;
            load_pending = 1'b0;
            next_tag     = 4'd1;
        end else begin
            // the cache sees our accept tag together with its command at this edge
            if (accept_tag != '0 && mem_command == bus_store) begin
                image[mem_addr] = mem_wdata;
            end else if (accept_tag != '0 && mem_command == bus_load) begin
                load_pending = 1'b1;
                load_tag     = accept_tag;
                load_addr    = mem_addr;
                resp_wait    = random_delay();
            end
            if (load_pending && resp_wait == 0) begin
                resp_tag     <= load_tag;
                rdata        <= image.exists(load_addr) ? image[load_addr]
                                                        : fill_pattern(load_addr);
                load_pending = 1'b0;
            end else if (load_pending) begin
                resp_wait--;
            end
            if (accept_tag == '0 && mem_command != bus_none &&
                !(hold_stores && mem_command == bus_store)) begin
                if (accept_wait == 0) begin
                    accept_tag  <= next_tag;
                    next_tag    = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                    accept_wait = random_delay();
                end else begin
                    accept_wait--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period = 8
) (
    output logic clock
);
    initial clock = 1'b0;

    always #(period / 2) clock = ~clock;

endmodule

`default_nettype wire
